// File: design/lsu_params.svh
/*
 * Load/store unit sizing defines
 * Queue depth, byte address width and reorder-buffer tag width shared by
 * the load queue and the core type packages
 */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Number of load queue entries
`define LQ_DEPTH 8

// Width of a byte address
`define LSU_ADDR_WIDTH 32

// Width of a reorder-buffer tag that can name each entry of a 64 entry ROB
`define LSU_TAG_WIDTH 6

`endif

// File: design/core_types_pkg.sv
/*
 * Core-wide types
 * Byte address and reorder-buffer tag types used by every pipeline block
 * that tracks an instruction or touches memory
 */
`include "lsu_params.svh"

package core_types_pkg;

    // Byte address as seen by the load/store unit
    typedef logic [`LSU_ADDR_WIDTH-1:0] core_addr_t;

    // Reorder-buffer tag that names an in-flight instruction
    typedef logic [`LSU_TAG_WIDTH-1:0] core_tag_t;

endpackage

// File: design/lsu_types_pkg.sv
/*
 * Load/store unit types
 * Memory operation function codes and the load queue slot index
 */
`include "lsu_params.svh"

package lsu_types_pkg;

    // Load and store functions carried by an LSU operation
    // Any code outside this list is handled as a word access
    typedef enum logic [2:0] {
        LSU_FUNC_LB = 3'b000,
        LSU_FUNC_LH = 3'b001,
        LSU_FUNC_LW = 3'b010,
        LSU_FUNC_SB = 3'b011,
        LSU_FUNC_SH = 3'b100,
        LSU_FUNC_SW = 3'b101
    } lsu_func_t;

    // Binary index of one load queue entry
    typedef logic [$clog2(`LQ_DEPTH)-1:0] lq_slot_t;

endpackage

// File: design/lq_front.sv
/*
 * Load queue front end
 * Chooses the lowest free entry for a new load, flags the queue as full
 * and turns a retiring store into the half-open byte range [start, end)
 * that every entry compares its load address against
 */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lq_front #(
    parameter int LQ_DEPTH = `LQ_DEPTH
) (
    input  logic                       [LQ_DEPTH-1:0] i_slot_valid,
    input  logic                                      i_alloc_en,
    input  logic                                      i_sq_retire_en,
    input  core_types_pkg::core_addr_t                i_sq_retire_addr,
    input  lsu_types_pkg::lsu_func_t                  i_sq_retire_lsu_func,
    output logic                       [LQ_DEPTH-1:0] o_alloc_select,
    output logic                                      o_full,
    output core_types_pkg::core_addr_t                o_st_start,
    output core_types_pkg::core_addr_t                o_st_end,
    output logic                                      o_st_check
);

    import core_types_pkg::*;
    import lsu_types_pkg::*;

    logic [LQ_DEPTH-1:0] free;
    logic [LQ_DEPTH-1:0] lowest_free;
    core_addr_t          st_bytes;

    // An entry is free whenever its valid bit is clear
    assign free = ~i_slot_valid;

    // Two's complement trick that keeps only the lowest set bit of free
    assign lowest_free = free & (~free + LQ_DEPTH'(1));

    // Full when not a single entry is free
    assign o_full = ~|free;

    // The one-hot select only fires for a real allocation with room left
    assign o_alloc_select = lowest_free & {LQ_DEPTH{i_alloc_en & ~o_full}};

    // Number of bytes the retiring store writes
    always_comb begin
        case (i_sq_retire_lsu_func)
            LSU_FUNC_SB: st_bytes = core_addr_t'(1);
            LSU_FUNC_SH: st_bytes = core_addr_t'(2);
            LSU_FUNC_SW: st_bytes = core_addr_t'(4);
            default:     st_bytes = core_addr_t'(4);
        endcase
    end

    // The range end is exclusive, so a byte store at A covers only A
    assign o_st_start = i_sq_retire_addr;
    assign o_st_end   = i_sq_retire_addr + st_bytes;

    // Entries only update their flag while a store is actually retiring
    assign o_st_check = i_sq_retire_en;

endmodule

// File: design/lq_entry.sv
/*
 * Load queue entry
 * Holds one in-flight load with its address, ROB tag, valid bit and
 * mis-speculation flag, and does its own tag match for retirement and
 * its own overlap compare against a retiring store
 */
`timescale 1ns/1ps

module lq_entry (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       i_flush,
    input  logic                       i_alloc,
    input  core_types_pkg::core_tag_t  i_alloc_tag,
    input  core_types_pkg::core_addr_t i_alloc_addr,
    input  logic                       i_st_check,
    input  core_types_pkg::core_addr_t i_st_start,
    input  core_types_pkg::core_addr_t i_st_end,
    input  logic                       i_retire,
    input  core_types_pkg::core_tag_t  i_retire_tag,
    output logic                       o_valid,
    output logic                       o_tag_match,
    output logic                       o_mis_speculated
);

    import core_types_pkg::*;

    core_addr_t addr;
    core_tag_t  tag;
    logic       st_overlap;

    // Flush wins over everything, then allocation, then retirement
    // Allocation and retirement never target the same entry in one cycle
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (i_alloc) begin
            o_valid <= 1'b1;
        end else if (i_retire) begin
            o_valid <= 1'b0;
        end
    end

    // Load payload is captured once when the entry is handed out
    always_ff @(posedge clk) begin
        if (i_alloc) begin
            addr <= i_alloc_addr;
            tag  <= i_alloc_tag;
        end
    end

    // Only a valid entry may answer a retire request
    assign o_tag_match = o_valid && (tag == i_retire_tag);

    // The load start address falls in the bytes the store writes
    assign st_overlap = (addr >= i_st_start) && (addr < i_st_end);

    // A fresh load starts clean, and a hit from a retiring store sticks
    // until the entry is reused
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_mis_speculated <= 1'b0;
        end else if (i_alloc) begin
            o_mis_speculated <= 1'b0;
        end else if (o_valid && i_st_check && st_overlap) begin
            o_mis_speculated <= 1'b1;
        end
    end

endmodule

// File: design/lq_retire.sv
/*
 * Load queue retire logic
 * Qualifies the entries' tag matches with the ROB retire strobe, encodes
 * the matching entry into a slot index and returns its mis-speculation flag
 */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lq_retire #(
    parameter int LQ_DEPTH = `LQ_DEPTH
) (
    input  logic                i_rob_retire_en,
    input  logic [LQ_DEPTH-1:0] i_tag_match,
    input  logic [LQ_DEPTH-1:0] i_mis_speculated,
    output logic [LQ_DEPTH-1:0] o_retire_select,
    output logic                o_rob_retire_mis_speculated
);

    import lsu_types_pkg::*;

    lq_slot_t retire_slot;
    logic     retire_hit;

    // Tags are unique among valid loads, so at most one bit survives
    assign o_retire_select = i_tag_match & {LQ_DEPTH{i_rob_retire_en}};
    assign retire_hit      = |o_retire_select;

    // One-hot to binary by OR-ing the index of every set bit
    always_comb begin
        retire_slot = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (o_retire_select[i]) begin
                retire_slot = retire_slot | lq_slot_t'(i);
            end
        end
    end

    // An idle strobe or an unknown tag must never report a mis-speculation
    // The flag read here is the value before any store lands this cycle
    assign o_rob_retire_mis_speculated = retire_hit && i_mis_speculated[retire_slot];

endmodule

// File: design/lsu_lq.sv
/*
 * Load queue of the load/store unit
 * Tracks issued loads until the ROB retires them and marks any load whose
 * address a retiring store writes, so the ROB can replay it
 */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_lq #(
    parameter int LQ_DEPTH = `LQ_DEPTH
) (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       i_flush,
    input  logic                       i_alloc_en,
    input  core_types_pkg::core_tag_t  i_alloc_tag,
    input  core_types_pkg::core_addr_t i_alloc_addr,
    input  logic                       i_sq_retire_en,
    input  core_types_pkg::core_addr_t i_sq_retire_addr,
    input  lsu_types_pkg::lsu_func_t   i_sq_retire_lsu_func,
    input  logic                       i_rob_retire_en,
    input  core_types_pkg::core_tag_t  i_rob_retire_tag,
    output logic                       o_full,
    output logic                       o_rob_retire_mis_speculated
);

    import core_types_pkg::*;

    logic [LQ_DEPTH-1:0] slot_valid;
    logic [LQ_DEPTH-1:0] alloc_select;
    logic [LQ_DEPTH-1:0] tag_match;
    logic [LQ_DEPTH-1:0] mis_speculated;
    logic [LQ_DEPTH-1:0] retire_select;
    core_addr_t          st_start;
    core_addr_t          st_end;
    logic                st_check;

    // Free slot choice, full flag and store range decode
    lq_front #(
        .LQ_DEPTH(LQ_DEPTH)
    ) u_front (
        .i_slot_valid        (slot_valid),
        .i_alloc_en          (i_alloc_en),
        .i_sq_retire_en      (i_sq_retire_en),
        .i_sq_retire_addr    (i_sq_retire_addr),
        .i_sq_retire_lsu_func(i_sq_retire_lsu_func),
        .o_alloc_select      (alloc_select),
        .o_full              (o_full),
        .o_st_start          (st_start),
        .o_st_end            (st_end),
        .o_st_check          (st_check)
    );

    // Every entry sees the same allocation data and store range
    for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_entry
        lq_entry u_entry (
            .clk             (clk),
            .n_rst           (n_rst),
            .i_flush         (i_flush),
            .i_alloc         (alloc_select[i]),
            .i_alloc_tag     (i_alloc_tag),
            .i_alloc_addr    (i_alloc_addr),
            .i_st_check      (st_check),
            .i_st_start      (st_start),
            .i_st_end        (st_end),
            .i_retire        (retire_select[i]),
            .i_retire_tag    (i_rob_retire_tag),
            .o_valid         (slot_valid[i]),
            .o_tag_match     (tag_match[i]),
            .o_mis_speculated(mis_speculated[i])
        );
    end

    // Retirement by tag and mis-speculation report back to the ROB
    lq_retire #(
        .LQ_DEPTH(LQ_DEPTH)
    ) u_retire (
        .i_rob_retire_en            (i_rob_retire_en),
        .i_tag_match                (tag_match),
        .i_mis_speculated           (mis_speculated),
        .o_retire_select            (retire_select),
        .o_rob_retire_mis_speculated(o_rob_retire_mis_speculated)
    );

endmodule

// File: verification/lsu_lq_tb.sv
/*
 * Load queue testbench
 * Replays a cycle-by-cycle stimulus file against the load queue, compares
 * the full flag and the retire mis-speculation report with the expected
 * columns of each row, and reports every test and the totals
 */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_lq_tb;

    import core_types_pkg::*;
    import lsu_types_pkg::*;

    // Upper bounds for the reset wait and the file loop
    localparam int RESET_TIMEOUT = 32;
    localparam int LINE_LIMIT    = 1000;

    logic       clk;
    logic       n_rst;
    logic       i_flush;
    logic       i_alloc_en;
    core_tag_t  i_alloc_tag;
    core_addr_t i_alloc_addr;
    logic       i_sq_retire_en;
    core_addr_t i_sq_retire_addr;
    lsu_func_t  i_sq_retire_lsu_func;
    logic       i_rob_retire_en;
    core_tag_t  i_rob_retire_tag;
    logic       o_full;
    logic       o_rob_retire_mis_speculated;

    // Fields of the stimulus row being applied
    int         row_test;
    logic       row_alloc_en;
    core_tag_t  row_alloc_tag;
    core_addr_t row_alloc_addr;
    logic       row_sq_en;
    core_addr_t row_sq_addr;
    logic [2:0] row_func;
    logic       row_rob_en;
    core_tag_t  row_rob_tag;
    logic       row_flush;
    logic       row_full;
    logic       row_mis;

    // Per-test and whole-run bookkeeping
    int cur_test;
    int test_cycles;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int check_count;
    int mismatch_count;
    int failures;

    lsu_lq #(
        .LQ_DEPTH(`LQ_DEPTH)
    ) uut (
        .clk                        (clk),
        .n_rst                      (n_rst),
        .i_flush                    (i_flush),
        .i_alloc_en                 (i_alloc_en),
        .i_alloc_tag                (i_alloc_tag),
        .i_alloc_addr               (i_alloc_addr),
        .i_sq_retire_en             (i_sq_retire_en),
        .i_sq_retire_addr           (i_sq_retire_addr),
        .i_sq_retire_lsu_func       (i_sq_retire_lsu_func),
        .i_rob_retire_en            (i_rob_retire_en),
        .i_rob_retire_tag           (i_rob_retire_tag),
        .o_full                     (o_full),
        .o_rob_retire_mis_speculated(o_rob_retire_mis_speculated)
    );

    // 100 ns clock, rising edges at 50, 150, 250 and so on
    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // Reset is held low for the first 8 clock periods
    initial begin
        n_rst = 1'b0;
        repeat (8) @(negedge clk);
        n_rst = 1'b1;
    end

    // The full flag depends only on the entry states
    task automatic check_full(input logic expected);
        check_count++;
        if (o_full !== expected) begin
            $display("MISMATCH time %0t signal o_full expected %0b actual %0b",
                     $time, expected, o_full);
            mismatch_count++;
            test_errors++;
        end
    endtask

    // The retire report follows the retire strobe and tag of this cycle
    task automatic check_mis_speculated(input logic expected);
        check_count++;
        if (o_rob_retire_mis_speculated !== expected) begin
            $display("MISMATCH time %0t signal o_rob_retire_mis_speculated expected %0b actual %0b",
                     $time, expected, o_rob_retire_mis_speculated);
            mismatch_count++;
            test_errors++;
        end
    endtask

    // One line for the test that just finished
    task automatic report_test();
        if (test_errors == 0) begin
            $display("test %0d PASS after %0d cycles", cur_test, test_cycles);
            tests_passed++;
        end else begin
            $display("test %0d FAIL with %0d mismatches", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // Polls at the rising edge, where n_rst is stable
    task automatic wait_for_reset(output bit released);
        int cycles;
        cycles = 0;
        while (n_rst !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        released = (n_rst === 1'b1);
    endtask

    // Drives one row on the falling edge and checks 10 ns before the rising edge
    task automatic apply_row();
        @(negedge clk);
        if (row_test != cur_test) begin
            if (cur_test >= 0) begin
                report_test();
            end
            cur_test    = row_test;
            test_cycles = 0;
            test_errors = 0;
        end
        i_alloc_en           = row_alloc_en;
        i_alloc_tag          = row_alloc_tag;
        i_alloc_addr         = row_alloc_addr;
        i_sq_retire_en       = row_sq_en;
        i_sq_retire_addr     = row_sq_addr;
        i_sq_retire_lsu_func = lsu_func_t'(row_func);
        i_rob_retire_en      = row_rob_en;
        i_rob_retire_tag     = row_rob_tag;
        i_flush              = row_flush;
        test_cycles++;
        #40;
        check_full(row_full);
        check_mis_speculated(row_mis);
    endtask

    // Lines that start with # describe the columns and are skipped
    task automatic run_stimulus();
        int    fd;
        int    lines;
        int    code;
        int    fields;
        string text;
        fd = $fopen("verification/lq_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verification/lq_stim.txt");
            failures++;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < LINE_LIMIT) begin
                lines++;
                text = "";
                code = $fgets(text, fd);
                if (code != 0 && text.substr(0, 0) != "#") begin
                    fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                     row_test, row_alloc_en, row_alloc_tag,
                                     row_alloc_addr, row_sq_en, row_sq_addr, row_func,
                                     row_rob_en, row_rob_tag, row_flush, row_full, row_mis);
                    if (fields == 12) begin
                        apply_row();
                    end else if (fields > 0) begin
                        $display("Stimulus line %0d is malformed and was skipped", lines);
                        failures++;
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("Gave up after %0d stimulus lines without reaching the end of the file",
                         lines);
                failures++;
            end
            $fclose(fd);
            if (cur_test >= 0) begin
                report_test();
            end
        end
    endtask

    // Closing totals and the final verdict
    task automatic finish_run();
        $display("tests %0d, passed %0d, failed %0d, checks %0d, mismatches %0d, other errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 check_count, mismatch_count, failures);
        if (mismatch_count == 0 && failures == 0 && tests_passed > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        bit released;
        i_flush              = 1'b0;
        i_alloc_en           = 1'b0;
        i_alloc_tag          = '0;
        i_alloc_addr         = '0;
        i_sq_retire_en       = 1'b0;
        i_sq_retire_addr     = '0;
        i_sq_retire_lsu_func = LSU_FUNC_LB;
        i_rob_retire_en      = 1'b0;
        i_rob_retire_tag     = '0;
        cur_test             = -1;
        test_cycles          = 0;
        test_errors          = 0;
        tests_passed         = 0;
        tests_failed         = 0;
        check_count          = 0;
        mismatch_count       = 0;
        failures             = 0;
        wait_for_reset(released);
        if (!released) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            failures++;
        end else begin
            run_stimulus();
        end
        finish_run();
    end

endmodule

// File: verification/lq_stim.txt
# test alloc_en alloc_tag alloc_addr sq_en sq_addr sq_func rob_en rob_tag flush exp_full exp_mis
# All hex, one line per clock cycle, sq_func 3 = SB, 4 = SH, 5 = SW
1 1 01 00001000 0 00000000 0 0 00 0 0 0
1 1 02 00001010 0 00000000 0 0 00 0 0 0
1 1 03 00001020 0 00000000 0 0 00 0 0 0
1 1 04 00001030 0 00000000 0 0 00 0 0 0
1 1 05 00001040 0 00000000 0 0 00 0 0 0
1 1 06 00001050 0 00000000 0 0 00 0 0 0
1 1 07 00001060 0 00000000 0 0 00 0 0 0
1 1 08 00001070 0 00000000 0 0 00 0 0 0
1 1 09 00001080 0 00000000 0 0 00 0 1 0
1 0 00 00000000 0 00000000 0 1 09 0 1 0
2 0 00 00000000 0 00000000 0 1 03 0 1 0
2 0 00 00000000 0 00000000 0 0 00 0 0 0
2 1 0a 00002000 0 00000000 0 0 00 0 0 0
2 0 00 00000000 0 00000000 0 0 00 0 1 0
3 0 00 00000000 0 00000000 0 0 00 1 1 0
3 1 10 00003000 0 00000000 0 0 00 0 0 0
3 1 11 00003001 0 00000000 0 0 00 0 0 0
3 1 12 00003002 0 00000000 0 0 00 0 0 0
3 1 13 00003003 0 00000000 0 0 00 0 0 0
3 1 14 00003004 0 00000000 0 0 00 0 0 0
3 0 00 00000000 1 00003000 5 0 00 0 0 0
3 1 15 00004000 0 00000000 0 1 10 0 0 1
3 1 16 00004001 0 00000000 0 1 11 0 0 1
3 1 17 00004002 0 00000000 0 1 12 0 0 1
3 1 18 00005000 0 00000000 0 1 13 0 0 1
3 1 19 00005001 0 00000000 0 1 14 0 0 0
3 0 00 00000000 1 00004000 4 0 00 0 0 0
3 0 00 00000000 1 00005000 3 0 00 0 0 0
3 0 00 00000000 0 00000000 0 1 15 0 0 1
3 0 00 00000000 0 00000000 0 1 16 0 0 1
3 0 00 00000000 0 00000000 0 1 17 0 0 0
3 0 00 00000000 0 00000000 0 1 18 0 0 1
3 0 00 00000000 0 00000000 0 1 19 0 0 0
4 1 20 00006000 0 00000000 0 0 00 0 0 0
4 0 00 00000000 1 00006000 5 0 00 0 0 0
4 0 00 00000000 0 00000000 0 1 20 0 0 1
4 1 21 00006000 0 00000000 0 0 00 0 0 0
4 0 00 00000000 0 00000000 0 1 21 0 0 0
5 1 22 00007000 0 00000000 0 0 00 0 0 0
5 1 23 00007004 0 00000000 0 0 00 0 0 0
5 0 00 00000000 1 00007000 5 0 00 0 0 0
5 1 24 00007000 0 00000000 0 0 00 1 0 0
5 0 00 00000000 0 00000000 0 1 22 0 0 0
5 0 00 00000000 0 00000000 0 1 23 0 0 0
5 0 00 00000000 0 00000000 0 1 24 0 0 0
6 1 30 00008000 0 00000000 0 0 00 0 0 0
6 1 31 00008010 0 00000000 0 0 00 0 0 0
6 0 00 00000000 1 00008000 5 0 00 0 0 0
6 0 00 00000000 0 00008010 5 0 00 0 0 0
6 0 00 00000000 0 00000000 0 0 30 0 0 0
6 0 00 00000000 0 00000000 0 1 3f 0 0 0
6 0 00 00000000 0 00000000 0 1 30 0 0 1
6 0 00 00000000 0 00000000 0 1 31 0 0 0

// File: all.f
+incdir+design
design/core_types_pkg.sv
design/lsu_types_pkg.sv
design/lq_front.sv
design/lq_entry.sv
design/lq_retire.sv
design/lsu_lq.sv
verification/lsu_lq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the load queue testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    -f all.f \
    --top-module lsu_lq_tb \
    -o sim_lsu_lq

output=$(./obj_dir/sim_lsu_lq)
echo "$output"

if echo "$output" | grep -q "^TEST OK$"; then
    exit 0
else
    exit 1
fi
